//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rd_req_arbiter
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/rd_req_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rd_req_checker import rra_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input port_mask_t in_fifo_re,
  input port_mask_t in_fifo_we,
  input port_mask_t in_fifo_full,
  input logic       out_fifo_we,
  input logic       out_fifo_full,
  input port_mask_t req_wr_available_in
);

  int failures;

  a_one_read: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(in_fifo_re))
    else begin
      $error("Both input FIFOs were read in one cycle");
      failures++;
    end

  a_in_full: assert property (@(posedge clk) disable iff (!arst_n)
                              (in_fifo_we & in_fifo_full) == 2'b00)
    else begin
      $error("Write into a full input FIFO");
      failures++;
    end

  a_out_full: assert property (@(posedge clk) disable iff (!arst_n)
                               !(out_fifo_we && out_fifo_full))
    else begin
      $error("Write into the full output FIFO");
      failures++;
    end

  a_reset_avail: assert property (@(posedge clk) !arst_n |-> req_wr_available_in == 2'b00)
    else begin
      $error("Upstream available level high during reset");
      failures++;
    end

endmodule

bind rd_req_arbiter rd_req_checker u_rd_req_checker (
  .clk                 (clk),
  .arst_n              (arst_n),
  .in_fifo_re          (in_fifo_re),
  .in_fifo_we          (in_fifo_we),
  .in_fifo_full        (in_fifo_full),
  .out_fifo_we         (out_fifo_we),
  .out_fifo_full       (out_fifo_full),
  .req_wr_available_in (req_wr_available_in)
);

`default_nettype wire

//--- sim/rd_req_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module rd_req_monitor import rra_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  port_mask_t      req_wr_en_in,
  input  req_data_t [1:0] req_wr_data_in,
  input  logic            req_wr_available_out,
  input  logic            req_wr_en_out,
  input  req_data_t       req_wr_data_out,
  output int              error_count,
  output int              words_out,
  output int              pending,
  output int              max_run
);

  int exp_q_0 [$];
  int exp_q_1 [$];
  int run_len;
  int last_port;
  int late_words;

  // Reference model. Port in bit 31, sequence number below it.
  function automatic void decode_word(input req_data_t word, output int port, output int seq);
    port = int'(word[31]);
    seq  = int'(word[30:0]);
  endfunction

  always @(posedge clk) begin
    int port;
    int seq;
    int exp_seq;
    int other;
    if (arst_n) begin
      for (int p = 0; p < 2; p++) begin
        if (req_wr_en_in[p]) begin
          decode_word(req_wr_data_in[p], port, seq);
          if (p == 0) begin
            exp_q_0.push_back(seq);
          end else begin
            exp_q_1.push_back(seq);
          end
        end
      end
      late_words = req_wr_available_out ? 0 : late_words + int'(req_wr_en_out);
      if (req_wr_en_out && late_words > 3) begin
        $display("More than three words arrived after downstream dropped its level");
        error_count++;
      end
      if (req_wr_en_out) begin
        words_out++;
        decode_word(req_wr_data_out, port, seq);
        other = (port == 0) ? exp_q_1.size() : exp_q_0.size();
        if ((port == 0 ? exp_q_0.size() : exp_q_1.size()) == 0) begin
          $display("Word %h left the DUT with nothing pending on its port", req_wr_data_out);
          error_count++;
        end else begin
          if (port == 0) begin
            exp_seq = exp_q_0.pop_front();
          end else begin
            exp_seq = exp_q_1.pop_front();
          end
          if (seq != exp_seq) begin
            $display("Mismatch req_wr_data_out expected %h actual %h",
                     {port[0], exp_seq[30:0]}, req_wr_data_out);
            error_count++;
          end
        end
        run_len   = (other == 0) ? 0 : ((port == last_port) ? run_len + 1 : 1);
        last_port = port; // A run only counts while the other port waits.
        max_run   = (run_len > max_run) ? run_len : max_run;
      end
    end
    pending = exp_q_0.size() + exp_q_1.size();
  end

endmodule

`default_nettype wire

//--- sim/tb_rd_req_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rd_req_arbiter import rra_pkg::*; ();

  localparam int LIGHT_WORDS     = 20;
  localparam int SAT_WORDS       = 200; // Per port.
  localparam int BP_WORDS        = 100;
  localparam int LIMIT_WORDS     = 40;
  localparam int TOTAL_WORDS     = LIGHT_WORDS + 2 * (SAT_WORDS + BP_WORDS + LIMIT_WORDS);
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

  logic            clk;
  logic            arst_n;
  port_mask_t      req_wr_en_in;
  req_data_t [1:0] req_wr_data_in;
  port_mask_t      req_wr_available_in;
  logic            req_wr_available_out;
  logic            req_wr_en_out;
  req_data_t       req_wr_data_out;

  int error_count;
  int words_out;
  int pending;
  int max_run;
  int next_seq [2];
  int ds_mode;      // 0 always available, 1 held off, 2 random.
  int tb_errors;
  int tests_failed;
  int test_base;

  rd_req_arbiter u_rd_req_arbiter (
    .clk                  (clk),
    .arst_n               (arst_n),
    .req_wr_en_in         (req_wr_en_in),
    .req_wr_data_in       (req_wr_data_in),
    .req_wr_available_in  (req_wr_available_in),
    .req_wr_available_out (req_wr_available_out),
    .req_wr_en_out        (req_wr_en_out),
    .req_wr_data_out      (req_wr_data_out)
  );

  rd_req_monitor u_rd_req_monitor (
    .clk                  (clk),
    .arst_n               (arst_n),
    .req_wr_en_in         (req_wr_en_in),
    .req_wr_data_in       (req_wr_data_in),
    .req_wr_available_out (req_wr_available_out),
    .req_wr_en_out        (req_wr_en_out),
    .req_wr_data_out      (req_wr_data_out),
    .error_count          (error_count),
    .words_out            (words_out),
    .pending              (pending),
    .max_run              (max_run)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles, %0d words pending", WATCHDOG_CYCLES, pending);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    req_wr_available_out = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      req_wr_available_out = (ds_mode == 2) ? ($urandom_range(1, 0) == 1) : (ds_mode == 0);
    end
  end

  function automatic int total_errors();
    return error_count + tb_errors + u_rd_req_arbiter.u_rd_req_checker.failures;
  endfunction

  task automatic write_port(input int port, input int count, input int gap_min,
                            input int gap_span);
    int sent;
    int idle;
    sent = 0;
    idle = 0;
    while (sent < count) begin
      @(posedge clk);
      #1;
      req_wr_en_in[port] = 1'b0;
      if (idle > 0) begin
        idle--;
      end else if (req_wr_available_in[port]) begin
        req_wr_en_in[port]   = 1'b1;
        req_wr_data_in[port] = {port[0], 31'(next_seq[port])}; // Port in bit 31.
        next_seq[port]++;
        sent++;
        idle = gap_min + int'($urandom_range(gap_span, 0));
      end
    end
    @(posedge clk);
    #1;
    req_wr_en_in[port] = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (pending != 0 && waited < 4000) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pending != 0) begin
      $display("%0d words never left the DUT", pending);
      tb_errors++;
    end
    repeat (20) @(posedge clk);
    #1;
  endtask

  task automatic hold_and_release();
    int waited;
    int seen;
    waited = 0;
    while (req_wr_available_in != 2'b00 && waited < 500) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (req_wr_available_in != 2'b00) begin
      $display("Available bits did not fall while downstream was held off");
      tb_errors++;
    end
    seen = words_out;
    repeat (50) @(posedge clk);
    #1;
    if (words_out != seen) begin
      $display("Words left the DUT while downstream was held off");
      tb_errors++;
    end
    ds_mode = 0;
  endtask

  task automatic expect_idle(input string phase);
    if (req_wr_en_out !== 1'b0) begin
      $display("Mismatch req_wr_en_out %s expected %h actual %h",
               phase, 1'b0, req_wr_en_out);
      tb_errors++;
    end
    if (req_wr_available_in !== 2'b00) begin
      $display("Mismatch req_wr_available_in %s expected %h actual %h",
               phase, 2'b00, req_wr_available_in);
      tb_errors++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - test_base;
    test_base = total_errors();
    if (errs == 0) begin
      $display("%-20s passed", name);
    end else begin
      $display("%-20s failed with %0d errors", name, errs);
      tests_failed++;
    end
  endtask

  initial begin
    void'($urandom(32'ha225));
    arst_n         = 1'b1;
    req_wr_en_in   = '0;
    req_wr_data_in = '0;
    #1;
    arst_n = 1'b0;
    repeat (10) begin
      @(posedge clk);
      #1;
      expect_idle("during reset");
    end
    arst_n = 1'b1;
    @(posedge clk);
    #1;
    expect_idle("on the first cycle after reset");
    for (int i = 0; i < 10 && req_wr_available_in != 2'b11; i++) begin
      @(posedge clk);
      #1;
    end
    if (req_wr_available_in != 2'b11) begin
      $display("Available bits did not rise after reset");
      tb_errors++;
    end
    end_test("reset");

    write_port(0, LIGHT_WORDS, 10, 10); // Isolated words use the trickle path.
    wait_drained();
    end_test("light traffic");

    fork
      write_port(0, SAT_WORDS, 0, 0);
      write_port(1, SAT_WORDS, 0, 0);
    join
    wait_drained();
    if (max_run > 16) begin
      $display("One port sent %0d words in a row while the other waited", max_run);
      tb_errors++;
    end
    end_test("saturated ports");

    ds_mode = 2;
    fork
      write_port(0, BP_WORDS, 0, 3);
      write_port(1, BP_WORDS, 0, 3);
    join
    ds_mode = 0;
    wait_drained();
    end_test("back-pressure");

    ds_mode = 1;
    fork
      write_port(0, LIMIT_WORDS, 0, 0);
      write_port(1, LIMIT_WORDS, 0, 0);
      hold_and_release();
    join
    wait_drained();
    end_test("upstream limit");

    $display("Summary: 5 tests, %0d failed, %0d errors, %0d words checked",
             tests_failed, total_errors(), words_out);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/rd_req_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "rra_consts.svh"

module rd_req_arbiter import rra_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  port_mask_t      req_wr_en_in,
  input  req_data_t [1:0] req_wr_data_in,
  output port_mask_t      req_wr_available_in,
  input  logic            req_wr_available_out,
  output logic            req_wr_en_out,
  output req_data_t       req_wr_data_out
);

  rst_vec_t        rst;

  port_mask_t      in_fifo_we;
  req_data_t [1:0] in_fifo_din;
  port_mask_t      in_fifo_re;
  port_mask_t      in_fifo_valid;
  req_data_t [1:0] in_fifo_dout;
  port_mask_t      in_fifo_empty;
  port_mask_t      in_fifo_full;
  port_mask_t      in_fifo_afull;
  port_mask_t      in_fifo_aempty;

  logic            out_fifo_we;
  req_data_t       out_fifo_din;
  logic            out_fifo_re;
  logic            out_fifo_valid;
  req_data_t       out_fifo_dout;
  logic            out_fifo_empty;
  logic            out_fifo_full;
  logic            out_fifo_afull;
  logic            out_fifo_aempty;

  port_mask_t      stream_req;
  port_mask_t      stream_grant;
  logic            stream_valid;
  port_mask_t      trickle_req;
  port_mask_t      trickle_grant;
  logic            trickle_valid;
  logic            trickle_fire;
  logic [1:0]      throttle_cnt;

  logic            select_valid;
  req_data_t       select_dout;

  reset_tree u_reset_tree (
    .clk    (clk),
    .arst_n (arst_n),
    .rst    (rst)
  );

  sync_fifo #(
    .WIDTH      (`RRA_DATA_WIDTH),
    .DEPTH_BITS (`RRA_IN_DEPTH_BITS),
    .AFULL      (`RRA_IN_AFULL),
    .AEMPTY     (`RRA_IN_AEMPTY)
  ) u_in_fifo_0 (
    .clk         (clk),
    .rst         (rst[0]),
    .we          (in_fifo_we[0]),
    .din         (in_fifo_din[0]),
    .re          (in_fifo_re[0]),
    .valid       (in_fifo_valid[0]),
    .dout        (in_fifo_dout[0]),
    .count       (),
    .empty       (in_fifo_empty[0]),
    .full        (in_fifo_full[0]),
    .almostfull  (in_fifo_afull[0]),
    .almostempty (in_fifo_aempty[0])
  );

  sync_fifo #(
    .WIDTH      (`RRA_DATA_WIDTH),
    .DEPTH_BITS (`RRA_IN_DEPTH_BITS),
    .AFULL      (`RRA_IN_AFULL),
    .AEMPTY     (`RRA_IN_AEMPTY)
  ) u_in_fifo_1 (
    .clk         (clk),
    .rst         (rst[1]),
    .we          (in_fifo_we[1]),
    .din         (in_fifo_din[1]),
    .re          (in_fifo_re[1]),
    .valid       (in_fifo_valid[1]),
    .dout        (in_fifo_dout[1]),
    .count       (),
    .empty       (in_fifo_empty[1]),
    .full        (in_fifo_full[1]),
    .almostfull  (in_fifo_afull[1]),
    .almostempty (in_fifo_aempty[1])
  );

  req_select u_req_select (
    .clk            (clk),
    .rst            (rst[2]),
    .data_in_valid  (in_fifo_valid),
    .data_in_0      (in_fifo_dout[0]),
    .data_in_1      (in_fifo_dout[1]),
    .data_out_valid (select_valid),
    .data_out       (select_dout)
  );

  sync_fifo #(
    .WIDTH      (`RRA_DATA_WIDTH),
    .DEPTH_BITS (`RRA_OUT_DEPTH_BITS),
    .AFULL      (`RRA_OUT_AFULL),
    .AEMPTY     (`RRA_OUT_AEMPTY)
  ) u_out_fifo (
    .clk         (clk),
    .rst         (rst[3]),
    .we          (out_fifo_we),
    .din         (out_fifo_din),
    .re          (out_fifo_re),
    .valid       (out_fifo_valid),
    .dout        (out_fifo_dout),
    .count       (),
    .empty       (out_fifo_empty),
    .full        (out_fifo_full),
    .almostfull  (out_fifo_afull),
    .almostempty (out_fifo_aempty)
  );

  rr_arbiter u_stream_arb (
    .clk           (clk),
    .rst           (rst[4]),
    .request       (stream_req),
    .grant         (stream_grant),
    .grant_valid   (stream_valid),
    .grant_encoded ()
  );

  rr_arbiter u_trickle_arb (
    .clk           (clk),
    .rst           (rst[5]),
    .request       (trickle_req),
    .grant         (trickle_grant),
    .grant_valid   (trickle_valid),
    .grant_encoded ()
  );

  // A full output side stalls both arbiters.
  assign stream_req  = ~in_fifo_aempty & {2{~out_fifo_afull}};
  assign trickle_req = ~in_fifo_empty & {2{~out_fifo_afull}};

  // Trickle reads only in idle streaming cycles, spaced by the throttle.
  assign trickle_fire = ~stream_valid & trickle_valid & (throttle_cnt == 2'd0);

  always_ff @(posedge clk or posedge rst[6]) begin
    if (rst[6]) begin
      req_wr_available_in <= '0;
    end else begin
      req_wr_available_in <= ~in_fifo_afull;
    end
  end

  always_ff @(posedge clk or posedge rst[7]) begin
    if (rst[7]) begin
      in_fifo_we    <= '0;
      in_fifo_re    <= '0;
      throttle_cnt  <= '0;
      out_fifo_we   <= 1'b0;
      out_fifo_re   <= 1'b0;
      req_wr_en_out <= 1'b0;
    end else begin
      in_fifo_we  <= req_wr_en_in;
      out_fifo_we <= select_valid;
      if (stream_valid) begin
        in_fifo_re <= stream_grant;
      end else if (trickle_fire) begin
        in_fifo_re <= trickle_grant;
      end else begin
        in_fifo_re <= '0;
      end
      if (trickle_fire) begin
        throttle_cnt <= 2'd2; // Lets the read's valid return first.
      end else if (throttle_cnt != 2'd0) begin
        throttle_cnt <= throttle_cnt - 2'd1;
      end
      if (out_fifo_aempty) begin
        out_fifo_re <= req_wr_available_out & ~out_fifo_empty & ~out_fifo_re;
      end else begin
        out_fifo_re <= req_wr_available_out;
      end
      req_wr_en_out <= out_fifo_valid;
    end
  end

  always_ff @(posedge clk) begin
    in_fifo_din     <= req_wr_data_in;
    out_fifo_din    <= select_dout;
    req_wr_data_out <= out_fifo_dout;
  end

endmodule

`default_nettype wire

//--- source/req_select.sv
`timescale 1ns/1ns
`default_nettype none

module req_select import rra_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  port_mask_t data_in_valid,
  input  req_data_t  data_in_0,
  input  req_data_t  data_in_1,
  output logic       data_out_valid,
  output req_data_t  data_out
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else begin
      data_out_valid <= |data_in_valid;
    end
  end

  // At most one input is valid, since only one FIFO is read per cycle.
  always_ff @(posedge clk) begin
    if (data_in_valid[1]) begin
      data_out <= data_in_1;
    end else if (data_in_valid[0]) begin
      data_out <= data_in_0;
    end
  end

endmodule

`default_nettype wire

//--- source/reset_tree.sv
`timescale 1ns/1ns
`default_nettype none

module reset_tree import rra_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  output rst_vec_t rst
);

  logic meta_n;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      meta_n <= 1'b0;
    end else begin
      meta_n <= 1'b1; // First synchronizer stage.
    end
  end

  // Second stage is replicated so each block gets its own low-fanout net.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst <= '1;
    end else begin
      rst <= {$bits(rst_vec_t){~meta_n}};
    end
  end

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter import rra_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  port_mask_t request,
  output port_mask_t grant,
  output logic       grant_valid,
  output logic       grant_encoded
);

  logic last_grant;
  logic prio;

  // The port after the last one granted goes first.
  assign prio = ~last_grant;

  assign grant_valid = |request;

  always_comb begin
    if (request[prio]) begin
      grant_encoded = prio;
    end else begin
      grant_encoded = ~prio;
    end
  end

  always_comb begin
    grant = '0;
    if (grant_valid) begin
      grant[grant_encoded] = 1'b1;
    end
  end

  // Reset points at port 1 so port 0 wins the first contest.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_grant <= 1'b1;
    end else if (grant_valid) begin
      last_grant <= grant_encoded;
    end
  end

endmodule

`default_nettype wire

//--- source/rra_consts.svh
`ifndef RRA_CONSTS_SVH
`define RRA_CONSTS_SVH

// Request word width.
`define RRA_DATA_WIDTH 32

// FIFO depths as log2 of the entry count.
`define RRA_IN_DEPTH_BITS 4
`define RRA_OUT_DEPTH_BITS 4

// Almost-full leaves six entries for words already in flight.
`define RRA_IN_AFULL ((1 << `RRA_IN_DEPTH_BITS) - 6)
`define RRA_OUT_AFULL ((1 << `RRA_OUT_DEPTH_BITS) - 6)

// Below this fill the trickle arbiter takes over from the streaming one.
`define RRA_IN_AEMPTY 4

// Below this fill output reads are spaced.
`define RRA_OUT_AEMPTY 2

`endif

//--- source/rra_pkg.sv
`default_nettype none

`include "rra_consts.svh"

package rra_pkg;

  // One request word.
  typedef logic [`RRA_DATA_WIDTH-1:0] req_data_t;

  // One bit per input port.
  typedef logic [1:0] port_mask_t;

  // Per-block reset nets from the reset tree.
  typedef logic [7:0] rst_vec_t;

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_BITS = 4,
  parameter int AFULL      = 10,
  parameter int AEMPTY     = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  logic [WIDTH-1:0]      din,
  input  logic                  re,
  output logic                  valid,
  output logic [WIDTH-1:0]      dout,
  output logic [DEPTH_BITS:0]   count,
  output logic                  empty,
  output logic                  full,
  output logic                  almostfull,
  output logic                  almostempty
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  typedef logic [DEPTH_BITS:0] cnt_t;
  typedef logic [DEPTH_BITS-1:0] ptr_t;

  logic [WIDTH-1:0] mem [DEPTH];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  logic             wr_ok;
  logic             rd_ok;

  assign empty       = (count == '0);
  assign full        = (count == cnt_t'(DEPTH));
  assign almostfull  = (count >= cnt_t'(AFULL));
  assign almostempty = (count <= cnt_t'(AEMPTY));

  assign wr_ok = we & ~full;  // Writes into a full FIFO are dropped.
  assign rd_ok = re & ~empty; // Reads from an empty FIFO are dropped.

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_ok) begin
      dout <= mem[rd_ptr]; // Registered read data.
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= rd_ok; // Pulses with the data one cycle after the read.
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/rra_pkg.sv
source/reset_tree.sv
source/sync_fifo.sv
source/rr_arbiter.sv
source/req_select.sv
source/rd_req_arbiter.sv
sim/rd_req_checker.sv
sim/rd_req_monitor.sv
sim/tb_rd_req_arbiter.sv
